//--- common/axi_bridge_pkg.sv
package axi_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int LEN_W  = 8;
    localparam int ID_W   = 4;

    // AXI IDs double as port numbers
    localparam logic [ID_W-1:0] PORT_IF   = 4'd1;
    localparam logic [ID_W-1:0] PORT_DATA = 4'd2;

    localparam logic [1:0] BURST_INCR = 2'b01;

    // Also the depth of the W queue
    localparam int MAX_BEATS = 8;
    localparam int WCNT_W    = 5;

    typedef struct packed {
        logic              req;
        logic              wr;
        logic [1:0]        size;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [STRB_W-1:0] wstrb;
        logic [DATA_W-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } sram_wbeat_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } axi_addr_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

endpackage

//--- axi_bridge/axi_ar_channel.sv
`timescale 1ns/1ps

module axi_ar_channel (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      req_valid,
    input  axi_bridge_pkg::axi_addr_t req,
    output logic                      addr_ok,
    output axi_bridge_pkg::axi_addr_t ar,
    output logic                      arvalid,
    input  logic                      arready
);

    logic take;

    // Free slot, or the current one leaves this cycle
    assign addr_ok = !arvalid || arready;
    assign take    = req_valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            arvalid <= 1'b0;
        end else if (take) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ar <= req;
        end
    end

    // Payload held until the slave takes it
    ar_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

endmodule

//--- axi_bridge/axi_r_channel.sv
`timescale 1ns/1ps

module axi_r_channel (
    input  logic                              clk,
    input  logic                              resetn,
    input  axi_bridge_pkg::axi_r_t            r,
    input  logic                              rvalid,
    output logic                              rready,
    output logic                              data_ok,
    output logic [axi_bridge_pkg::ID_W-1:0]   id,
    output logic [axi_bridge_pkg::DATA_W-1:0] data
);
    import axi_bridge_pkg::*;

    logic            in_burst;
    logic [ID_W-1:0] burst_id;

    // Always ready once out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rready <= 1'b0;
        end else begin
            rready <= 1'b1;
        end
    end

    assign data_ok = rvalid && rready;
    assign id      = r.id;
    assign data    = r.data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_burst <= 1'b0;
        end else if (data_ok) begin
            in_burst <= !r.last;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok) begin
            burst_id <= r.id;
        end
    end

    rid_known: assert property (
        @(posedge clk) disable iff (!resetn)
        rvalid |-> (r.id == PORT_IF || r.id == PORT_DATA)
    );

    // No interleaving, a burst closes with rlast before another starts
    rid_in_burst: assert property (
        @(posedge clk) disable iff (!resetn)
        rvalid && in_burst |-> r.id == burst_id
    );

endmodule

//--- axi_bridge/axi_aw_channel.sv
`timescale 1ns/1ps

module axi_aw_channel (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        req_valid,
    input  axi_bridge_pkg::axi_addr_t   req,
    input  axi_bridge_pkg::sram_wbeat_t wbeat,
    input  logic                        wbeat_valid,
    output logic                        addr_ok,
    output axi_bridge_pkg::axi_addr_t   aw,
    output logic                        awvalid,
    input  logic                        awready,
    output axi_bridge_pkg::axi_w_t      w,
    output logic                        wvalid,
    input  logic                        wready
);
    import axi_bridge_pkg::*;

    sram_wbeat_t                  wq [MAX_BEATS];
    logic [$clog2(MAX_BEATS)-1:0] wr_ptr;
    logic [$clog2(MAX_BEATS)-1:0] rd_ptr;
    logic [$clog2(MAX_BEATS):0]   count;
    logic                         take;
    logic                         push;
    logic                         pop;
    sram_wbeat_t                  head;

    // One write at a time, and only once the previous beats are gone
    assign addr_ok = !awvalid && (count == '0);
    assign take    = req_valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            awvalid <= 1'b0;
        end else if (take) begin
            awvalid <= 1'b1;
        end else if (awready) begin
            awvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            aw <= req;
        end
    end

    // W beat queue
    assign push = wbeat_valid;
    assign pop  = wvalid && wready;
    assign head = wq[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            wq[wr_ptr] <= wbeat;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign wvalid = (count != '0);
    assign w      = '{id: PORT_DATA, data: head.data, strb: head.strb, last: head.last};

    wq_no_overflow: assert property (
        @(posedge clk) disable iff (!resetn)
        push && !pop |-> count != MAX_BEATS
    );

endmodule

//--- axi_bridge/axi_b_channel.sv
`timescale 1ns/1ps

module axi_b_channel (
    input  logic                   clk,
    input  logic                   resetn,
    input  axi_bridge_pkg::axi_b_t b,
    input  logic                   bvalid,
    output logic                   bready,
    output logic                   data_ok
);
    import axi_bridge_pkg::*;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bready <= 1'b0;
        end else begin
            bready <= 1'b1;
        end
    end

    // bresp ignored, every response counts as done
    assign data_ok = bvalid && bready;

    // Only the data port writes
    bid_data_port: assert property (
        @(posedge clk) disable iff (!resetn)
        bvalid |-> b.id == PORT_DATA
    );

endmodule

//--- axi_bridge/axi_bridge.sv
`timescale 1ns/1ps

module axi_bridge (
    input  logic                              clk,
    input  logic                              resetn,
    input  axi_bridge_pkg::sram_req_t         if_req,
    input  axi_bridge_pkg::sram_req_t         data_req,
    input  axi_bridge_pkg::sram_wbeat_t       wbeat,
    input  logic                              wbeat_valid,
    output logic                              if_addr_ok,
    output logic                              if_data_ok,
    output logic                              data_addr_ok,
    output logic                              data_data_ok,
    output logic [axi_bridge_pkg::DATA_W-1:0] rdata,
    output axi_bridge_pkg::axi_addr_t         ar,
    output logic                              arvalid,
    input  logic                              arready,
    input  axi_bridge_pkg::axi_r_t            r,
    input  logic                              rvalid,
    output logic                              rready,
    output axi_bridge_pkg::axi_addr_t         aw,
    output logic                              awvalid,
    input  logic                              awready,
    output axi_bridge_pkg::axi_w_t            w,
    output logic                              wvalid,
    input  logic                              wready,
    input  axi_bridge_pkg::axi_b_t            b,
    input  logic                              bvalid,
    output logic                              bready
);
    import axi_bridge_pkg::*;

    logic              if_rd;
    logic              data_rd;
    logic              data_wr;
    logic              data_rd_go;
    logic              ar_req_valid;
    axi_addr_t         ar_req;
    axi_addr_t         aw_req;
    logic              ar_addr_ok;
    logic              aw_addr_ok;
    logic              r_data_ok;
    logic [ID_W-1:0]   r_id;
    logic              b_data_ok;
    logic              wr_take;
    logic [WCNT_W-1:0] wcnt;

    function automatic axi_addr_t to_axi(input logic [ID_W-1:0] port, input sram_req_t src);
        axi_addr_t a;
        a.id    = port;
        a.addr  = src.addr;
        a.len   = src.len;
        a.size  = {1'b0, src.size};
        a.burst = BURST_INCR;
        a.lock  = '0;
        a.cache = '0;
        a.prot  = '0;
        return a;
    endfunction

    assign if_rd   = if_req.req && !if_req.wr;
    assign data_rd = data_req.req && !data_req.wr;
    assign data_wr = data_req.req && data_req.wr;

    // Data reads wait out pending writes (RAW), and beat fetches otherwise
    assign data_rd_go   = data_rd && (wcnt == '0);
    assign ar_req_valid = data_rd_go || if_rd;
    assign ar_req       = data_rd_go ? to_axi(PORT_DATA, data_req) : to_axi(PORT_IF, if_req);
    assign aw_req       = to_axi(PORT_DATA, data_req);

    assign if_addr_ok   = if_rd && !data_rd_go && ar_addr_ok;
    assign data_addr_ok = data_wr ? aw_addr_ok : (data_rd_go && ar_addr_ok);

    assign if_data_ok   = r_data_ok && (r_id == PORT_IF);
    assign data_data_ok = (r_data_ok && (r_id == PORT_DATA)) || b_data_ok;

    // Outstanding writes
    assign wr_take = data_wr && aw_addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wcnt <= '0;
        end else if (wr_take && !b_data_ok) begin
            wcnt <= wcnt + 1'b1;
        end else if (b_data_ok && !wr_take) begin
            wcnt <= wcnt - 1'b1;
        end
    end

    wcnt_no_underflow: assert property (
        @(posedge clk) disable iff (!resetn)
        b_data_ok |-> wcnt != '0
    );

    axi_ar_channel u_ar (
        .clk       (clk),
        .resetn    (resetn),
        .req_valid (ar_req_valid),
        .req       (ar_req),
        .addr_ok   (ar_addr_ok),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready)
    );

    axi_r_channel u_r (
        .clk     (clk),
        .resetn  (resetn),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .data_ok (r_data_ok),
        .id      (r_id),
        .data    (rdata)
    );

    axi_aw_channel u_aw (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid   (data_wr),
        .req         (aw_req),
        .wbeat       (wbeat),
        .wbeat_valid (wbeat_valid),
        .addr_ok     (aw_addr_ok),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready)
    );

    axi_b_channel u_b (
        .clk     (clk),
        .resetn  (resetn),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .data_ok (b_data_ok)
    );

endmodule

//--- tests/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
    input  logic                      clk,
    input  logic                      resetn,
    input  axi_bridge_pkg::axi_addr_t ar,
    input  logic                      arvalid,
    output logic                      arready,
    output axi_bridge_pkg::axi_r_t    r,
    output logic                      rvalid,
    input  logic                      rready,
    input  axi_bridge_pkg::axi_addr_t aw,
    input  logic                      awvalid,
    output logic                      awready,
    input  axi_bridge_pkg::axi_w_t    w,
    input  logic                      wvalid,
    output logic                      wready,
    output axi_bridge_pkg::axi_b_t    b,
    output logic                      bvalid,
    input  logic                      bready
);
    import axi_bridge_pkg::*;

    localparam int MEM_WORDS = 256;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    integer            seed;
    logic              rd_busy;
    axi_addr_t         rd_cmd;
    logic [LEN_W-1:0]  rd_beat;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_busy;
    logic              b_pend;
    axi_addr_t         wr_cmd;
    logic [LEN_W-1:0]  wr_beat;
    logic [ADDR_W-1:0] wr_addr;

    // Each word starts as its byte address XOR a marker
    initial begin
        seed = 56;
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        rd_cmd  = '0;
        wr_cmd  = '0;
        rd_beat = '0;
        wr_beat = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 4) ^ 32'h5A5A0000;
        end
    end

    assign rd_addr = rd_cmd.addr + ADDR_W'({rd_beat, 2'b00});
    assign wr_addr = wr_cmd.addr + ADDR_W'({wr_beat, 2'b00});
    assign r = '{id: rd_cmd.id, data: mem[rd_addr[9:2]], resp: 2'b00,
                 last: (rd_beat == rd_cmd.len)};
    assign b = '{id: wr_cmd.id, resp: 2'b00};

    always @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_busy <= 1'b0;
            rd_beat <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
            wr_beat <= '0;
        end else begin
            // One read burst at a time
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_cmd  <= ar;
                rd_beat <= '0;
            end else if (!rd_busy) begin
                arready <= (($random(seed) & 3) != 0);
            end
            if (rd_busy) begin
                if (rvalid && rready) begin
                    rvalid <= !r.last && (($random(seed) & 3) != 0);
                    if (r.last) begin
                        rd_busy <= 1'b0;
                    end else begin
                        rd_beat <= rd_beat + LEN_W'(1);
                    end
                end else if (!rvalid) begin
                    rvalid <= (($random(seed) & 3) != 0);
                end
            end

            // Write path: AW, then W beats, then B
            if (!wr_busy) begin
                if (awvalid && awready) begin
                    awready <= 1'b0;
                    wr_busy <= 1'b1;
                    wr_cmd  <= aw;
                    wr_beat <= '0;
                end else begin
                    awready <= (($random(seed) & 3) != 0);
                end
            end else if (wvalid && wready) begin
                for (int k = 0; k < STRB_W; k++) begin
                    if (w.strb[k]) begin
                        mem[wr_addr[9:2]][k*8 +: 8] <= w.data[k*8 +: 8];
                    end
                end
                wready <= !w.last && (($random(seed) & 3) != 0);
                if (w.last) begin
                    b_pend <= 1'b1;
                end else begin
                    wr_beat <= wr_beat + LEN_W'(1);
                end
            end else if (bvalid && bready) begin
                bvalid  <= 1'b0;
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end else if (b_pend) begin
                bvalid <= bvalid || (($random(seed) & 3) != 0);
            end else begin
                wready <= (($random(seed) & 3) != 0);
            end
        end
    end

endmodule

//--- tests/tb_axi_bridge.sv
`timescale 1ns/1ps

module tb_axi_bridge;
    import axi_bridge_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int TRACE_WORDS  = 256;

    logic              clk;
    logic              resetn;
    sram_req_t         if_req;
    sram_req_t         data_req;
    sram_wbeat_t       wbeat;
    logic              wbeat_valid;
    logic              if_addr_ok;
    logic              if_data_ok;
    logic              data_addr_ok;
    logic              data_data_ok;
    logic [DATA_W-1:0] rdata;
    axi_addr_t         ar;
    logic              arvalid;
    logic              arready;
    axi_r_t            r;
    logic              rvalid;
    logic              rready;
    axi_addr_t         aw;
    logic              awvalid;
    logic              awready;
    axi_w_t            w;
    logic              wvalid;
    logic              wready;
    axi_b_t            b;
    logic              bvalid;
    logic              bready;

    logic [31:0]       trace [TRACE_WORDS];
    int                fetch_recs [$];
    int                data_recs [$];
    logic [DATA_W-1:0] if_exp [$];
    logic [DATA_W-1:0] data_exp [$];
    int                total_beats;
    int                exp_if_beats;
    int                exp_data_beats;
    int                if_beats;
    int                data_beats;
    int                writes_issued;
    int                writes_done;
    logic              parsed;
    logic              started;

    axi_bridge axi_bridge_i (.*);

    axi_slave_model slave (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] got,
                            input logic [ID_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Size, burst, lock, cache and prot of an AR or AW payload
    task automatic check_attr(input string name, input axi_addr_t got);
        logic [13:0] attr;
        logic [13:0] exp;
        attr = {got.size, got.burst, got.lock, got.cache, got.prot};
        // Word beats and INCR bursts, the rest zero
        exp = {3'd2, 2'b01, 9'd0};
        if (attr !== exp) begin
            abort_run($sformatf("ERR %s got 0x%04h expected 0x%04h", name, attr, exp));
        end
    endtask

    // Record layout is kind, addr, len, then len+1 data words
    task automatic parse_trace();
        int p;
        int len;
        p = 0;
        while (p < TRACE_WORDS && trace[p] !== 32'd0) begin
            if ($isunknown(trace[p]) || trace[p] > 32'd3 || trace[p+2] >= MAX_BEATS) begin
                abort_run("Trace file is missing or holds a malformed record");
            end
            len = int'(trace[p+2]);
            if (trace[p] == 32'd1) begin
                fetch_recs.push_back(p);
                exp_if_beats += len + 1;
            end else begin
                data_recs.push_back(p);
                exp_data_beats += (trace[p] == 32'd3) ? 1 : len + 1;
            end
            total_beats += len + 1;
            p += len + 4;
        end
    endtask

    task automatic issue_fetches();
        int p;
        int len;
        while (fetch_recs.size() != 0) begin
            p = fetch_recs.pop_front();
            len = int'(trace[p+2]);
            for (int i = 0; i <= len; i++) begin
                if_exp.push_back(trace[p+3+i]);
            end
            if_req <= '{req: 1'b1, wr: 1'b0, size: 2'd2, addr: trace[p+1],
                        len: trace[p+2][LEN_W-1:0], wstrb: '0, wdata: '0};
            @(negedge clk);
            while (!if_addr_ok) @(negedge clk);
            @(posedge clk);
            if_req <= '0;
            while (if_exp.size() != 0) @(posedge clk);
        end
    endtask

    task automatic drive_data_port();
        int   p;
        int   len;
        logic wr;
        while (data_recs.size() != 0) begin
            p = data_recs.pop_front();
            len = int'(trace[p+2]);
            wr = (trace[p] == 32'd3);
            if (!wr) begin
                for (int i = 0; i <= len; i++) begin
                    data_exp.push_back(trace[p+3+i]);
                end
            end
            data_req <= '{req: 1'b1, wr: wr, size: 2'd2, addr: trace[p+1],
                          len: trace[p+2][LEN_W-1:0], wstrb: {STRB_W{1'b1}},
                          wdata: trace[p+3]};
            @(negedge clk);
            while (!data_addr_ok) @(negedge clk);
            @(posedge clk);
            data_req <= '0;
            if (wr) begin
                writes_issued++;
                // Beats follow the taken request, one per cycle
                for (int i = 0; i <= len; i++) begin
                    wbeat <= '{data: trace[p+3+i], strb: {STRB_W{1'b1}}, last: (i == len)};
                    wbeat_valid <= 1'b1;
                    @(posedge clk);
                end
                wbeat_valid <= 1'b0;
            end else begin
                while (data_exp.size() != 0) @(posedge clk);
            end
        end
    endtask

    always @(negedge clk) begin
        if (resetn && !started) begin
            check_flag("arvalid", arvalid, 1'b0);
            check_flag("awvalid", awvalid, 1'b0);
            check_flag("wvalid", wvalid, 1'b0);
            check_flag("if_data_ok", if_data_ok, 1'b0);
            check_flag("data_data_ok", data_data_ok, 1'b0);
        end
        if (resetn && started) begin
            check_flag("rready", rready, 1'b1);
            check_flag("bready", bready, 1'b1);
            if (arvalid) begin
                check_attr("ar", ar);
            end
            if (awvalid) begin
                check_attr("aw", aw);
            end
            // W beats carry the data port ID
            if (wvalid) begin
                check_id("w.id", w.id, 4'd2);
            end
            if (if_data_ok) begin
                if (if_exp.size() == 0) begin
                    abort_run("Fetch port returned data that was never requested");
                end else begin
                    check_rdata("if rdata", rdata, if_exp.pop_front());
                    if_beats++;
                end
            end
            // A pulse while a write is open is its B response
            if (data_data_ok) begin
                if (writes_done != writes_issued) begin
                    writes_done++;
                end else if (data_exp.size() == 0) begin
                    abort_run("Data port signalled completion with nothing outstanding");
                end else begin
                    check_rdata("data rdata", rdata, data_exp.pop_front());
                    data_beats++;
                end
            end
            if (data_req.req && !data_req.wr && data_addr_ok) begin
                check_count("write completions before data read", writes_done, writes_issued);
                if (if_req.req) begin
                    check_flag("if_addr_ok", if_addr_ok, 1'b0);
                end
            end
        end
    end

    initial begin
        resetn = 1'b0;
        if_req = '0;
        data_req = '0;
        wbeat = '0;
        wbeat_valid = 1'b0;
        parsed = 1'b0;
        started = 1'b0;
        $readmemh("tests/bridge_trace.txt", trace);
        parse_trace();
        parsed = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);
        started = 1'b1;
        fork
            issue_fetches();
            drive_data_port();
        join
        repeat (4) @(posedge clk);
        check_count("if_data_ok pulses", if_beats, exp_if_beats);
        check_count("data_data_ok pulses", data_beats + writes_done, exp_data_beats);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (parsed);
        repeat (RESET_CYCLES + 40 * total_beats) @(posedge clk);
        abort_run("Watchdog timeout, the trace did not finish in time");
    end

endmodule

//--- tests/bridge_trace.txt
// kind addr len words; kind 1 fetch read, 2 data read, 3 data write, 0 ends the trace
// Reads list the expected words, writes list the words written
00000001 00000040 00000000 5A5A0040
00000002 00000300 00000001 5A5A0300 5A5A0304
00000001 00000080 00000003 5A5A0080 5A5A0084 5A5A0088 5A5A008C
00000003 00000380 00000003 11111111 22222222 33333333 44444444
00000002 00000380 00000003 11111111 22222222 33333333 44444444
00000001 00000100 00000007
5A5A0100 5A5A0104 5A5A0108 5A5A010C
5A5A0110 5A5A0114 5A5A0118 5A5A011C
00000003 000003C0 00000000 CAFEF00D
00000002 000003C0 00000000 CAFEF00D
00000002 00000388 00000001 33333333 44444444
00000001 00000044 00000000 5A5A0044
00000003 00000390 00000007
A0000000 A1111111 A2222222 A3333333
A4444444 A5555555 A6666666 A7777777
00000002 00000390 00000007
A0000000 A1111111 A2222222 A3333333
A4444444 A5555555 A6666666 A7777777
00000001 00000200 00000001 5A5A0200 5A5A0204
00000000

//--- tb.f
common/axi_bridge_pkg.sv
axi_bridge/axi_ar_channel.sv
axi_bridge/axi_r_channel.sv
axi_bridge/axi_aw_channel.sv
axi_bridge/axi_b_channel.sv
axi_bridge/axi_bridge.sv
tests/axi_slave_model.sv
tests/tb_axi_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi_bridge -f tb.f -o tb_axi_bridge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axi_bridge > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
